// ==== fx_alu.f ====
source/fx_alu_pkg.sv
source/fx_alu_ctrl.sv
source/fx_arith.sv
source/bit_ops.sv
source/fx_alu_top.sv
bench/fx_alu_assert.sv
bench/fx_alu_tb.sv

// ==== Makefile ====
TOP := fx_alu_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): fx_alu.f source/*.sv bench/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f fx_alu.f

# pass only when the simulation prints the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

// ==== bench/fx_alu_tb.sv ====
`default_nettype none

module fx_alu_tb import fx_alu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 5;
    localparam int LFSR_STEPS = 8;
    localparam int N_RAND     = 16;
    localparam int N_MAC      = 16;
    // ops issued per test in run order
    localparam int NUM_OPS = 1 + (12 + 2 * N_RAND) + (9 + N_RAND) + (N_MAC + 3)
                           + (4 + N_RAND) + (3 + N_RAND) + 40 + 9;
    localparam int WATCHDOG_NS = (NUM_OPS * 3 + RST_CYCLES + 50) * CLK_PERIOD;

    logic     i_clk = 1'b0;
    logic     i_rst_n;
    alu_req_t i_req;
    logic     o_busy;
    logic     o_valid;
    fx_word_t o_data;

    fx_word_t model_acc;    // mirrors the result register
    int       err_cnt   = 0;
    int       check_cnt = 0;
    int       test_cnt  = 0;
    int       assert_fails;

    fx_alu_top #(
        .LFSR_MAX_STEPS (LFSR_STEPS)
    ) u_fx_alu_top (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_req   (i_req),
        .o_busy  (o_busy),
        .o_valid (o_valid),
        .o_data  (o_data)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    function automatic fx_word_t clamp_sum(input int s);
        if (s > 32767) begin
            return FX_MAX;
        end else if (s < -32768) begin
            return FX_MIN;
        end
        return fx_word_t'(s);
    endfunction

    // Q12.20 back to Q6.10 with saturation outside 26 bits signed
    function automatic fx_word_t round_product(input longint p);
        longint q;
        if (p > 64'sd33554431) begin
            return FX_MAX;
        end else if (p < -64'sd33554432) begin
            return FX_MIN;
        end
        q = p >>> 10;
        if (p[9] && q != 32767) begin
            q = q + 1;
        end
        return fx_word_t'(q);
    endfunction

    function automatic fx_word_t lead_zero_ref(input fx_word_t a);
        int n;
        n = 0;
        while (n < 16 && !a[15-n]) begin
            n++;
        end
        return fx_word_t'(n);
    endfunction

    function automatic fx_word_t rotate_ref(input fx_word_t a, input fx_word_t b);
        int       n;
        fx_word_t r;
        n = $countones(a);
        for (int i = 0; i < 16; i++) begin
            r[i] = (i < n) ? ~b[(i - n + 16) % 16] : b[(i - n + 16) % 16];  // low n wrapped
        end
        return r;
    endfunction

    function automatic fx_word_t lfsr_ref(input fx_word_t seed, input fx_word_t b);
        logic [15:0] w;
        logic [15:0] steps;
        w     = seed;
        steps = b;
        if (steps > LFSR_STEPS) begin
            return '0;
        end
        repeat (steps) begin
            w = {w[14:0], w[15] ^ w[13] ^ w[12] ^ w[10]};
        end
        return w;
    endfunction

    function automatic fx_word_t expected_result(input logic [3:0] op, input fx_word_t a,
                                                 input fx_word_t b, input fx_word_t acc);
        case (op)
            OP_FXADD: return clamp_sum(int'(a) + int'(b));
            OP_FXSUB: return clamp_sum(int'(a) - int'(b));
            OP_FXMUL: return round_product(longint'(a) * longint'(b));
            OP_FXMAC: return round_product(longint'(a) * longint'(b) + longint'(acc) * 1024);
            OP_CLZ:   return lead_zero_ref(a);
            OP_LRCW:  return rotate_ref(a, b);
            OP_LFSR:  return lfsr_ref(a, b);
            default:  return '0;
        endcase
    endfunction

    function automatic fx_word_t random_word(input int max_shift);
        fx_word_t w;
        w = fx_word_t'($urandom);
        return w >>> ($urandom % (max_shift + 1));   // spread the magnitudes
    endfunction

    task automatic check_word(input string what, input fx_word_t got, input fx_word_t exp);
        check_cnt++;
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %b expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // runs from a falling edge to the falling edge of the done cycle
    task automatic run_op(input logic [3:0] op, input fx_word_t a, input fx_word_t b,
                          output fx_word_t got);
        int waited;
        int cycles;
        waited = 0;
        while (o_busy && waited < 4) begin
            @(negedge i_clk);
            waited++;
        end
        if (o_busy) begin
            $display("no accept slot within %0d cycles at %0t", waited, $time);
            err_cnt++;
        end
        i_req  = {op, a, b};
        cycles = 0;
        do begin
            @(negedge i_clk);
            cycles++;
        end while (!o_valid && cycles < 6);
        if (!o_valid) begin
            $display("o_valid never rose for op %0d at %0t", op, $time);
            err_cnt++;
        end else if (cycles != 2) begin
            $display("o_valid came %0d cycles after accept, not 2, at %0t", cycles, $time);
            err_cnt++;
        end
        check_flag("o_busy in done cycle", o_busy, 1'b0);
        got   = o_data;
        i_req = {OP_FXADD, got, 16'h0000};  // x+0 keeps the accumulator if idle
    endtask

    task automatic verify_op(input logic [3:0] op, input fx_word_t a, input fx_word_t b);
        fx_word_t exp;
        fx_word_t got;
        exp = expected_result(op, a, b, model_acc);
        run_op(op, a, b, got);
        check_word($sformatf("op %0d a=%h b=%h", op, a, b), got, exp);
        model_acc = exp;
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, err_cnt - errs_before);
        end
    endtask

    task automatic test_reset_cadence();
        int errs;
        errs = err_cnt;
        check_flag("o_busy in reset", o_busy, 1'b1);
        check_flag("o_valid in reset", o_valid, 1'b0);
        i_rst_n = 1'b1;
        #1;
        check_flag("o_busy after release", o_busy, 1'b1);
        check_flag("o_valid after release", o_valid, 1'b0);
        @(negedge i_clk);
        check_flag("o_busy in first accept", o_busy, 1'b0);
        check_flag("o_valid in first accept", o_valid, 1'b0);
        verify_op(OP_FXADD, 16'sh0c00, 16'sh0400);     // 3.0 + 1.0
        report_test("reset_cadence", errs);
    endtask

    task automatic add_and_sub(input fx_word_t a, input fx_word_t b);
        verify_op(OP_FXADD, a, b);
        verify_op(OP_FXSUB, a, b);
    endtask

    task automatic test_add_sub();
        int errs;
        errs = err_cnt;
        add_and_sub(16'sh7fff, 16'sh0001);
        add_and_sub(16'sh8000, 16'sh0001);
        add_and_sub(16'sh8000, 16'sh8000);
        add_and_sub(16'sh7fff, 16'sh7fff);
        add_and_sub(16'sh0000, 16'sh8000);
        add_and_sub(16'sh0c00, 16'shf400);
        for (int i = 0; i < N_RAND; i++) begin
            add_and_sub(fx_word_t'($urandom), fx_word_t'($urandom));
        end
        report_test("add_sub", errs);
    endtask

    task automatic test_mul();
        int errs;
        errs = err_cnt;
        verify_op(OP_FXMUL, 16'sh7fff, 16'sh7fff);
        verify_op(OP_FXMUL, 16'sh8000, 16'sh7fff);
        verify_op(OP_FXMUL, 16'sh8000, 16'sh8000);
        verify_op(OP_FXMUL, 16'sh0400, 16'sh1234);     // times 1.0
        verify_op(OP_FXMUL, 16'sh0001, 16'sh0200);     // half lsb rounds up
        verify_op(OP_FXMUL, 16'sh0001, 16'sh01ff);
        verify_op(OP_FXMUL, 16'shffff, 16'sh0200);
        verify_op(OP_FXMUL, 16'sh1000, 16'sh2000);     // 32.0 just over the top
        verify_op(OP_FXMUL, 16'shf000, 16'sh2000);     // -32.0 lands exactly on min
        for (int i = 0; i < N_RAND; i++) begin
            verify_op(OP_FXMUL, random_word(7), random_word(7));
        end
        report_test("mul", errs);
    endtask

    task automatic test_mac_chain();
        int         errs;
        logic [3:0] op;
        errs = err_cnt;
        for (int i = 0; i < N_MAC; i++) begin
            case (i % 5)
                2:       op = OP_FXSUB;
                4:       op = (i % 2 == 0) ? 4'(OP_CLZ) : 4'd9;
                default: op = OP_FXMAC;
            endcase
            verify_op(op, random_word(6), random_word(6));
        end
        verify_op(OP_FXMAC, 16'sh2000, 16'sh1000);
        verify_op(OP_FXMAC, 16'sh0400, 16'shfc00);
        verify_op(OP_FXMAC, 16'sh0000, 16'sh0000);     // accumulator alone
        report_test("mac_chain", errs);
    endtask

    task automatic test_bit_ops();
        int       errs;
        fx_word_t w;
        fx_word_t seeds [4];
        errs = err_cnt;
        verify_op(OP_CLZ, 16'h0000, 16'h0000);
        verify_op(OP_CLZ, 16'hffff, 16'h0000);
        verify_op(OP_CLZ, 16'h0001, 16'h1234);
        verify_op(OP_CLZ, 16'h0080, 16'hffff);
        for (int i = 0; i < N_RAND; i++) begin
            w = fx_word_t'($urandom);
            verify_op(OP_CLZ, w >> ($urandom % 16), fx_word_t'($urandom));
        end
        verify_op(OP_LRCW, 16'h0000, 16'h5a3c);
        verify_op(OP_LRCW, 16'hffff, 16'h5a3c);
        verify_op(OP_LRCW, 16'h0001, 16'h8000);
        for (int i = 0; i < N_RAND; i++) begin
            verify_op(OP_LRCW, fx_word_t'($urandom), fx_word_t'($urandom));
        end
        seeds = '{16'hace1, 16'h0000, 16'hffff, fx_word_t'($urandom)};
        for (int s = 0; s < 4; s++) begin
            for (int st = 0; st < 10; st++) begin
                verify_op(OP_LFSR, seeds[s], fx_word_t'(st));
            end
        end
        report_test("bit_ops", errs);
    endtask

    task automatic test_undefined();
        int errs;
        errs = err_cnt;
        verify_op(4'd4, fx_word_t'($urandom), fx_word_t'($urandom));
        for (int op = 8; op < 16; op++) begin
            verify_op(4'(op), fx_word_t'($urandom), fx_word_t'($urandom));
        end
        report_test("undefined_ops", errs);
    endtask

    initial begin
        void'($urandom(32'he85d5422));
        i_rst_n   = 1'b0;
        i_req     = {OP_FXADD, 16'h0000, 16'h0000};
        model_acc = '0;
        repeat (RST_CYCLES) @(negedge i_clk);
        test_reset_cadence();
        test_add_sub();
        test_mul();
        test_mac_chain();
        test_bit_ops();
        test_undefined();
        assert_fails = u_fx_alu_top.u_ctrl.u_assert.fail_cnt;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 test_cnt, check_cnt, err_cnt, assert_fails);
        if (err_cnt == 0 && assert_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t, the DUT stopped answering", $time);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/fx_alu_assert.sv ====
`default_nettype none

module fx_alu_assert (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_busy,
    input logic i_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;   // read by the testbench at the end

    a_busy_valid_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_busy && i_valid))
    else begin
        fail_cnt++;
        $error("o_busy and o_valid high in the same cycle");
    end

    a_valid_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_valid |=> !i_valid)
    else begin
        fail_cnt++;
        $error("o_valid high on two cycles in a row");
    end

    // accept edge, one execute cycle, then the result
    a_accept_to_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_busy |=> !i_valid ##1 i_valid)
    else begin
        fail_cnt++;
        $error("o_valid not two cycles after accept");
    end

endmodule

bind fx_alu_ctrl fx_alu_assert u_assert (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_busy  (o_busy),
    .i_valid (o_valid)
);

`default_nettype wire

// ==== source/fx_alu_top.sv ====
`default_nettype none

module fx_alu_top import fx_alu_pkg::*; #(
    parameter int LFSR_MAX_STEPS = 8
)(
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  alu_req_t i_req,
    output logic     o_busy,
    output logic     o_valid,
    output fx_word_t o_data
);

    alu_req_t  cmd;
    fx_word_t  acc;
    unit_res_t arith_res;
    unit_res_t bit_res;

    fx_alu_ctrl u_ctrl (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req       (i_req),
        .i_arith_res (arith_res),
        .i_bit_res   (bit_res),
        .o_cmd       (cmd),
        .o_acc       (acc),
        .o_busy      (o_busy),
        .o_valid     (o_valid),
        .o_data      (o_data)
    );

    // both units see the same registered command
    fx_arith u_arith (
        .i_cmd (cmd),
        .i_acc (acc),
        .o_res (arith_res)
    );

    bit_ops #(
        .LFSR_MAX_STEPS (LFSR_MAX_STEPS)
    ) u_bit_ops (
        .i_cmd (cmd),
        .o_res (bit_res)
    );

endmodule

`default_nettype wire

// ==== source/bit_ops.sv ====
`default_nettype none

module bit_ops import fx_alu_pkg::*; #(
    parameter int LFSR_MAX_STEPS = 8
)(
    input  alu_req_t  i_cmd,
    output unit_res_t o_res
);

    localparam int CNT_W = $clog2(DATA_W + 1);   // holds 0..DATA_W

    logic [CNT_W-1:0]  lead_zeros;
    logic [CNT_W-1:0]  ones;
    logic [DATA_W-1:0] rot_word;
    logic [DATA_W-1:0] lfsr_word;

    function automatic logic [CNT_W-1:0] count_lead(input logic [DATA_W-1:0] w);
        logic [CNT_W-1:0] cnt;
        logic             seen;
        cnt  = '0;
        seen = 1'b0;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            seen = seen | w[i];
            if (!seen) begin
                cnt = cnt + 1'b1;
            end
        end
        return cnt;
    endfunction

    function automatic logic [CNT_W-1:0] count_ones(input logic [DATA_W-1:0] w);
        logic [CNT_W-1:0] cnt;
        cnt = '0;
        for (int i = 0; i < DATA_W; i++) begin
            cnt = cnt + CNT_W'(w[i]);
        end
        return cnt;
    endfunction

    // rotate left by n, wrapped bits come back inverted
    function automatic logic [DATA_W-1:0] rot_invert(input logic [DATA_W-1:0] w,
                                                     input logic [CNT_W-1:0]  n);
        logic [2*DATA_W-1:0] pair;
        pair = {w, ~w} << n;    // inverted copy trails the word
        return pair[2*DATA_W-1:DATA_W];
    endfunction

    function automatic logic [DATA_W-1:0] lfsr_step(input logic [DATA_W-1:0] w);
        return {w[14:0], w[15] ^ w[13] ^ w[12] ^ w[10]};   // taps 16,14,13,11
    endfunction

    function automatic logic [DATA_W-1:0] lfsr_run(input logic [DATA_W-1:0] seed,
                                                   input logic [DATA_W-1:0] steps);
        logic [DATA_W-1:0] w;
        w = seed;
        for (int i = 0; i < LFSR_MAX_STEPS; i++) begin
            if (i < int'(steps)) begin
                w = lfsr_step(w);
            end
        end
        return (int'(steps) > LFSR_MAX_STEPS) ? '0 : w;
    endfunction

    assign lead_zeros = count_lead(i_cmd.a);
    assign ones       = count_ones(i_cmd.a);
    assign rot_word   = rot_invert(i_cmd.b, ones);
    assign lfsr_word  = lfsr_run(i_cmd.a, i_cmd.b);

    always_comb begin
        o_res.hit   = 1'b1;
        o_res.value = '0;
        case (i_cmd.op)
            OP_CLZ:  o_res.value = {{(DATA_W - CNT_W){1'b0}}, lead_zeros};
            OP_LRCW: o_res.value = rot_word;
            OP_LFSR: o_res.value = lfsr_word;
            default: o_res.hit   = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/fx_arith.sv ====
`default_nettype none

module fx_arith import fx_alu_pkg::*; (
    input  alu_req_t  i_cmd,
    input  fx_word_t  i_acc,
    output unit_res_t o_res
);

    localparam int PROD_W   = 2 * DATA_W;
    localparam int KEEP_MSB = DATA_W + FRAC_W - 1;   // top of the kept window

    // signed range of the kept window, bits KEEP_MSB..0
    localparam logic signed [PROD_W-1:0] WIN_MAX = (2 ** KEEP_MSB) - 1;
    localparam logic signed [PROD_W-1:0] WIN_MIN = -(2 ** KEEP_MSB);

    fx_word_t                 op_a;
    fx_word_t                 op_b;
    logic signed [DATA_W:0]   sum_ext;
    logic signed [DATA_W:0]   diff_ext;
    logic signed [PROD_W-1:0] prod;
    logic signed [PROD_W-1:0] acc_ext;
    logic signed [PROD_W-1:0] mac_sum;

    function automatic fx_word_t clamp_word(input logic signed [DATA_W:0] x);
        if (x > FX_MAX) begin
            return FX_MAX;
        end else if (x < FX_MIN) begin
            return FX_MIN;
        end
        return x[DATA_W-1:0];
    endfunction

    // back to Q6.10, round half up on bit FRAC_W-1
    function automatic fx_word_t sat_round(input logic signed [PROD_W-1:0] full);
        fx_word_t kept;
        if (full > WIN_MAX) begin
            return FX_MAX;
        end else if (full < WIN_MIN) begin
            return FX_MIN;
        end
        kept = full[KEEP_MSB:FRAC_W];
        if (full[FRAC_W-1] && (kept != FX_MAX)) begin
            kept = kept + 1'b1;     // no wrap past max
        end
        return kept;
    endfunction

    assign op_a = i_cmd.a;
    assign op_b = i_cmd.b;

    assign sum_ext  = op_a + op_b;      // 17 bit exact
    assign diff_ext = op_a - op_b;
    assign prod     = op_a * op_b;      // Q12.20
    assign acc_ext  = i_acc;

    // accumulator lined up with the product fraction
    assign mac_sum = prod + (acc_ext <<< FRAC_W);

    always_comb begin
        o_res.hit   = 1'b1;
        o_res.value = '0;
        case (i_cmd.op)
            OP_FXADD: o_res.value = clamp_word(sum_ext);
            OP_FXSUB: o_res.value = clamp_word(diff_ext);
            OP_FXMUL: o_res.value = sat_round(prod);
            OP_FXMAC: o_res.value = sat_round(mac_sum);
            default:  o_res.hit   = 1'b0;   // not ours
        endcase
    end

endmodule

`default_nettype wire

// ==== source/fx_alu_ctrl.sv ====
`default_nettype none

module fx_alu_ctrl import fx_alu_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  alu_req_t  i_req,
    input  unit_res_t i_arith_res,
    input  unit_res_t i_bit_res,
    output alu_req_t  o_cmd,
    output fx_word_t  o_acc,
    output logic      o_busy,
    output logic      o_valid,
    output fx_word_t  o_data
);

    typedef enum logic [1:0] {
        ST_RST,       // held in reset, busy
        ST_ACCEPT,    // first free slot after reset
        ST_EXEC,
        ST_DONE       // result out, next request taken here too
    } state_t;

    state_t   state;
    state_t   state_nxt;
    logic     accept;
    alu_req_t cmd_q;
    fx_word_t res_sel;
    fx_word_t res_q;

    // fixed cadence, no waiting on the requester
    always_comb begin
        case (state)
            ST_RST:    state_nxt = ST_ACCEPT;
            ST_ACCEPT: state_nxt = ST_EXEC;
            ST_EXEC:   state_nxt = ST_DONE;
            ST_DONE:   state_nxt = ST_EXEC;
            default:   state_nxt = ST_RST;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= ST_RST;
        end else begin
            state <= state_nxt;
        end
    end

    assign accept = (state == ST_ACCEPT) || (state == ST_DONE);

    always_ff @(posedge i_clk) begin
        if (accept) begin
            cmd_q <= i_req;
        end
    end

    // owning unit wins, nobody owns it -> zero
    always_comb begin
        if (i_arith_res.hit) begin
            res_sel = i_arith_res.value;
        end else if (i_bit_res.hit) begin
            res_sel = i_bit_res.value;
        end else begin
            res_sel = '0;
        end
    end

    // output word is also the MAC accumulator
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            res_q <= '0;
        end else if (state == ST_EXEC) begin
            res_q <= res_sel;
        end
    end

    assign o_cmd   = cmd_q;
    assign o_acc   = res_q;
    assign o_data  = res_q;
    assign o_busy  = (state == ST_RST) || (state == ST_EXEC);
    assign o_valid = (state == ST_DONE);

endmodule

`default_nettype wire

// ==== source/fx_alu_pkg.sv ====
`default_nettype none

package fx_alu_pkg;

    localparam int INT_W  = 6;
    localparam int FRAC_W = 10;
    localparam int DATA_W = INT_W + FRAC_W;

    // Q6.10 signed word
    typedef logic signed [DATA_W-1:0] fx_word_t;

    typedef enum logic [3:0] {
        OP_FXADD = 4'd0,
        OP_FXSUB = 4'd1,
        OP_FXMUL = 4'd2,
        OP_FXMAC = 4'd3,
        OP_CLZ   = 4'd5,
        OP_LRCW  = 4'd6,
        OP_LFSR  = 4'd7
    } alu_op_t;   // 4 and 8..15 undefined, return zero

    typedef struct packed {
        alu_op_t  op;
        fx_word_t a;
        fx_word_t b;
    } alu_req_t;

    typedef struct packed {
        logic     hit;      // unit owns this op
        fx_word_t value;
    } unit_res_t;

    // saturation limits
    localparam fx_word_t FX_MAX = 16'sh7fff;
    localparam fx_word_t FX_MIN = 16'sh8000;

endpackage

`default_nettype wire
